//--- Makefile
# Verilator build and run of the router match-action testbench

SIM = obj_dir/Vp4_router_tb

all: run

$(SIM): project.f $(shell grep -v '^+' project.f)
	verilator --binary --timing --assert -Wno-fatal --top-module p4_router_tb \
		-f project.f -o Vp4_router_tb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- hdl/ctrl_agent.sv
// control slave on a four-phase req/ack handshake that decodes
// command words into table writes, clears and reads
`timescale 1ns/10ps

module ctrl_agent (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   ctrl_req,
    input  logic [router_ctrl_pkg::CMD_W-1:0]      ctrl_cmd,
    input  logic [router_ctrl_pkg::CMD_W-1:0]      rd_entry,
    output logic                                   ctrl_ack,
    output logic [router_ctrl_pkg::CMD_W-1:0]      ctrl_rdata,
    output logic                                   wr_en,
    output logic [router_ctrl_pkg::SLOT_W-1:0]     wr_slot,
    output logic                                   wr_valid,
    output logic [router_ctrl_pkg::KEY_W-1:0]      wr_key,
    output logic [router_port_pkg::PORT_ID_W-1:0]  wr_egr,
    output logic [router_ctrl_pkg::SLOT_W-1:0]     rd_slot
);

    typedef enum logic [1:0] {
        IDLE,    // waiting for req
        DONE,    // table op in flight and ack due on the next edge
        RELEASE  // ack high until req drops
    } state_e;

    state_e                     state_q;
    router_ctrl_pkg::ctrl_cmd_u cmd;
    router_ctrl_pkg::ctrl_op_e  op_q; // opcode of the request being served

    assign cmd = ctrl_cmd;

    //////////////////////////////////////////////////
    // handshake FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= IDLE;
            ctrl_ack <= 1'b0;
            wr_en    <= 1'b0;
            op_q     <= router_ctrl_pkg::OP_NOP;
        end else begin
            wr_en <= 1'b0; // single-cycle strobe
            case (state_q)
                IDLE: if (ctrl_req) begin
                    op_q    <= cmd.slot_view.op;
                    wr_en   <= (cmd.slot_view.op == router_ctrl_pkg::OP_WRITE) ||
                               (cmd.slot_view.op == router_ctrl_pkg::OP_CLEAR);
                    state_q <= DONE;
                end
                DONE: begin
                    ctrl_ack <= 1'b1; // same edge as the table update
                    state_q  <= RELEASE;
                end
                RELEASE: if (!ctrl_req) begin
                    ctrl_ack <= 1'b0;
                    state_q  <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // command fields decoded per opcode
    always_ff @(posedge clk) begin
        if (state_q == IDLE && ctrl_req) begin
            if (cmd.slot_view.op == router_ctrl_pkg::OP_WRITE) begin
                wr_valid <= cmd.entry_view.valid;
            end else begin
                wr_valid <= 1'b0;              // clear drops the entry
            end
            wr_slot <= cmd.slot_view.slot;
            wr_key  <= cmd.entry_view.key;     // don't care for clear
            wr_egr  <= cmd.entry_view.egr;
            rd_slot <= cmd.slot_view.slot;
        end
        if (state_q == DONE && op_q == router_ctrl_pkg::OP_READ) begin
            ctrl_rdata <= rd_entry; // held through RELEASE
        end
    end

    // ack only ever answers a request from the host
    ack_needs_req_a: assert property (@(posedge clk) disable iff (rst)
        !ctrl_req && !ctrl_ack |=> !ctrl_ack);

    wr_en_pulse_a: assert property (@(posedge clk) disable iff (rst)
        wr_en |=> !wr_en);

endmodule

//--- hdl/fwd_cam.sv
// forwarding table: 16 entries of valid, key and egress P4 id,
// with host write and read ports and a parallel lowest-slot match
`timescale 1ns/10ps

module fwd_cam (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wr_en,
    input  logic [router_ctrl_pkg::SLOT_W-1:0]     wr_slot,
    input  logic                                   wr_valid,
    input  logic [router_ctrl_pkg::KEY_W-1:0]      wr_key,
    input  logic [router_port_pkg::PORT_ID_W-1:0]  wr_egr,
    input  logic [router_ctrl_pkg::SLOT_W-1:0]     rd_slot,
    input  logic [router_ctrl_pkg::KEY_W-1:0]      lk_key,
    output logic [router_ctrl_pkg::CMD_W-1:0]      rd_entry,
    output logic                                   lk_hit,
    output logic [router_port_pkg::PORT_ID_W-1:0]  lk_egr
);

    logic [router_ctrl_pkg::TABLE_DEPTH-1:0] valid_q;                          // per-slot valid
    logic [router_ctrl_pkg::KEY_W-1:0]       key_q [router_ctrl_pkg::TABLE_DEPTH]; // keys
    logic [router_port_pkg::PORT_ID_W-1:0]   egr_q [router_ctrl_pkg::TABLE_DEPTH]; // egress ids
    router_ctrl_pkg::entry_view_t            rd_view;

    //////////////////////////////////////////////////
    // storage
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0; // table empty after reset
        end else if (wr_en) begin
            valid_q[wr_slot] <= wr_valid; // clear is a write with valid low
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            key_q[wr_slot] <= wr_key;
            egr_q[wr_slot] <= wr_egr;
        end
    end

    //////////////////////////////////////////////////
    // match, scanned downward so the lowest slot wins
    always_comb begin
        lk_hit = 1'b0;
        lk_egr = '0;
        for (int i = router_ctrl_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
            if (valid_q[i] && (key_q[i] == lk_key)) begin
                lk_hit = 1'b1;
                lk_egr = egr_q[i];
            end
        end
    end

    // readback in command layout, opcode field zero
    always_comb begin
        rd_view       = '0;
        rd_view.op    = router_ctrl_pkg::OP_NOP;
        rd_view.slot  = rd_slot;            // echo of the slot read
        rd_view.valid = valid_q[rd_slot];
        rd_view.egr   = egr_q[rd_slot];
        rd_view.key   = key_q[rd_slot];
    end

    assign rd_entry = rd_view;

    // a write to an unknown slot would corrupt an arbitrary entry
    wr_slot_known_a: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_slot));

endmodule

//--- hdl/lookup_pipe.sv
// two-stage metadata lookup: ingress id map and table match,
// then egress id map, with shared stall under back-pressure
`timescale 1ns/10ps

module lookup_pipe (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   meta_in_valid,
    input  logic [router_port_pkg::PORT_ID_W-1:0]  meta_in_ing_port,
    input  logic [router_ctrl_pkg::KEY_W-1:0]      meta_in_key,
    input  logic                                   meta_out_ready,
    input  logic                                   lk_hit,
    input  logic [router_port_pkg::PORT_ID_W-1:0]  lk_egr,
    output logic                                   meta_in_ready,
    output logic                                   meta_out_valid,
    output logic [router_port_pkg::PORT_ID_W-1:0]  meta_out_ing_port,
    output logic [router_port_pkg::PORT_ID_W-1:0]  meta_out_egr_spec,
    output logic [router_ctrl_pkg::KEY_W-1:0]      lk_key
);

    logic                                  advance;  // both stages move
    logic                                  s1_valid;
    logic [router_port_pkg::PORT_ID_W-1:0] s1_ing;   // P4 ingress id
    logic [router_port_pkg::PORT_ID_W-1:0] s1_egr;   // P4 egress id
    logic                                  s2_valid;
    logic [router_port_pkg::PORT_ID_W-1:0] s2_ing;
    logic [router_port_pkg::PORT_ID_W-1:0] s2_egr;   // RTL egress index

    assign advance       = !s2_valid || meta_out_ready;
    assign meta_in_ready = advance;
    assign lk_key        = meta_in_key; // table matched combinationally

    //////////////////////////////////////////////////
    // valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= meta_in_valid;
            s2_valid <= s1_valid;
        end
    end

    //////////////////////////////////////////////////
    // payload
    always_ff @(posedge clk) begin
        if (advance) begin
            // stage 1: map ingress, take hit or fall back to CPU
            s1_ing <= router_port_pkg::ingress_to_p4(meta_in_ing_port);
            s1_egr <= lk_hit ? lk_egr : router_port_pkg::CPU_P4_ID;
            // stage 2: back to the RTL egress index
            s2_ing <= s1_ing;
            s2_egr <= router_port_pkg::p4_to_egress(s1_egr);
        end
    end

    assign meta_out_valid    = s2_valid;
    assign meta_out_ing_port = s2_ing;
    assign meta_out_egr_spec = s2_egr;

    // held output must not move until the sink takes it
    out_hold_a: assert property (@(posedge clk) disable iff (rst)
        meta_out_valid && !meta_out_ready |=>
            meta_out_valid && $stable(meta_out_ing_port) && $stable(meta_out_egr_spec));

endmodule

//--- hdl/p4_router_core.sv
// match-action metadata stage: control agent, forwarding table and lookup pipe
`timescale 1ns/10ps

module p4_router_core (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   ctrl_req,
    input  logic [router_ctrl_pkg::CMD_W-1:0]      ctrl_cmd,
    output logic                                   ctrl_ack,
    output logic [router_ctrl_pkg::CMD_W-1:0]      ctrl_rdata,
    input  logic                                   meta_in_valid,
    output logic                                   meta_in_ready,
    input  logic [router_port_pkg::PORT_ID_W-1:0]  meta_in_ing_port,
    input  logic [router_ctrl_pkg::KEY_W-1:0]      meta_in_key,
    output logic                                   meta_out_valid,
    input  logic                                   meta_out_ready,
    output logic [router_port_pkg::PORT_ID_W-1:0]  meta_out_ing_port,
    output logic [router_port_pkg::PORT_ID_W-1:0]  meta_out_egr_spec
);

    logic                                  wr_en;    // agent -> table
    logic [router_ctrl_pkg::SLOT_W-1:0]    wr_slot;
    logic                                  wr_valid;
    logic [router_ctrl_pkg::KEY_W-1:0]     wr_key;
    logic [router_port_pkg::PORT_ID_W-1:0] wr_egr;
    logic [router_ctrl_pkg::SLOT_W-1:0]    rd_slot;
    logic [router_ctrl_pkg::CMD_W-1:0]     rd_entry; // table -> agent
    logic [router_ctrl_pkg::KEY_W-1:0]     lk_key;   // pipe <-> table
    logic                                  lk_hit;
    logic [router_port_pkg::PORT_ID_W-1:0] lk_egr;

    ctrl_agent u_ctrl_agent (
        .clk, .rst, .ctrl_req, .ctrl_cmd, .rd_entry, .ctrl_ack, .ctrl_rdata,
        .wr_en, .wr_slot, .wr_valid, .wr_key, .wr_egr, .rd_slot
    );

    fwd_cam u_fwd_cam (
        .clk, .rst, .wr_en, .wr_slot, .wr_valid, .wr_key, .wr_egr, .rd_slot,
        .lk_key, .rd_entry, .lk_hit, .lk_egr
    );

    lookup_pipe u_lookup_pipe (
        .clk, .rst, .meta_in_valid, .meta_in_ing_port, .meta_in_key, .meta_out_ready,
        .lk_hit, .lk_egr, .meta_in_ready, .meta_out_valid, .meta_out_ing_port,
        .meta_out_egr_spec, .lk_key
    );

endmodule

//--- hdl/router_ctrl_pkg.sv
// control port definitions: table geometry, opcodes and the command word
package router_ctrl_pkg;

    localparam int KEY_W       = 16; // destination key
    localparam int TABLE_DEPTH = 16;
    localparam int SLOT_W      = 4;  // log2 of TABLE_DEPTH
    localparam int CMD_W       = 32;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_WRITE,
        OP_CLEAR,
        OP_READ
    } ctrl_op_e;

    //////////////////////////////////////////////////
    // command word, also the readback layout with op = 0
    typedef struct packed {
        ctrl_op_e                               op;    // [31:30]
        logic [SLOT_W-1:0]                      slot;  // [29:26]
        logic                                   valid; // [25]
        logic [router_port_pkg::PORT_ID_W-1:0]  egr;   // [24:17] egress P4 id
        logic [KEY_W-1:0]                       key;   // [16:1]
        logic                                   spare; // [0]
    } entry_view_t;

    typedef struct packed {
        ctrl_op_e          op;
        logic [SLOT_W-1:0] slot;
        logic [25:0]       rsvd; // ignored for clear and read
    } slot_view_t;

    typedef union packed {
        entry_view_t entry_view; // OP_WRITE
        slot_view_t  slot_view;  // OP_CLEAR, OP_READ
    } ctrl_cmd_u;

endpackage

//--- hdl/router_port_pkg.sv
// router port ids: RTL port indices, P4 port ids and the mapping
// functions between the two numbering schemes
package router_port_pkg;

    localparam int PORT_ID_W = 8; // every port id, both directions

    //////////////////////////////////////////////////
    // RTL port indices, shared by ingress and egress
    localparam logic [PORT_ID_W-1:0] CPU_RTL_ID   = 8'd0;
    localparam logic [PORT_ID_W-1:0] OISL0_RTL_ID = 8'd1;
    localparam logic [PORT_ID_W-1:0] OISL1_RTL_ID = 8'd2;
    localparam logic [PORT_ID_W-1:0] ECP0_RTL_ID  = 8'd3;
    localparam logic [PORT_ID_W-1:0] ECP1_RTL_ID  = 8'd4;
    localparam logic [PORT_ID_W-1:0] HDR0_RTL_ID  = 8'd5;
    localparam logic [PORT_ID_W-1:0] HDR1_RTL_ID  = 8'd6;
    localparam logic [PORT_ID_W-1:0] ECG0_RTL_ID  = 8'd7;
    localparam logic [PORT_ID_W-1:0] ECG1_RTL_ID  = 8'd8;
    localparam logic [PORT_ID_W-1:0] ECG2_RTL_ID  = 8'd9;
    localparam logic [PORT_ID_W-1:0] ECG3_RTL_ID  = 8'd10;

    //////////////////////////////////////////////////
    // port ids as seen by the P4 program
    localparam logic [PORT_ID_W-1:0] CPU_P4_ID   = 8'd0;
    localparam logic [PORT_ID_W-1:0] OISL0_P4_ID = 8'd20;
    localparam logic [PORT_ID_W-1:0] OISL1_P4_ID = 8'd21;
    localparam logic [PORT_ID_W-1:0] ECP0_P4_ID  = 8'd40;
    localparam logic [PORT_ID_W-1:0] ECP1_P4_ID  = 8'd41;
    localparam logic [PORT_ID_W-1:0] HDR0_P4_ID  = 8'd60;
    localparam logic [PORT_ID_W-1:0] HDR1_P4_ID  = 8'd61;
    localparam logic [PORT_ID_W-1:0] ECG0_P4_ID  = 8'd80;
    localparam logic [PORT_ID_W-1:0] ECG1_P4_ID  = 8'd81;
    localparam logic [PORT_ID_W-1:0] ECG2_P4_ID  = 8'd82;
    localparam logic [PORT_ID_W-1:0] ECG3_P4_ID  = 8'd83;

    localparam logic [PORT_ID_W-1:0] NO_PORT_ID = 8'hFF; // unmapped id, either way

    // RTL ingress index -> P4 ingress id
    function automatic logic [PORT_ID_W-1:0] ingress_to_p4(input logic [PORT_ID_W-1:0] rtl_id);
        case (rtl_id)
            CPU_RTL_ID   : return CPU_P4_ID;
            OISL0_RTL_ID : return OISL0_P4_ID;
            OISL1_RTL_ID : return OISL1_P4_ID;
            ECP0_RTL_ID  : return ECP0_P4_ID;
            ECP1_RTL_ID  : return ECP1_P4_ID;
            HDR0_RTL_ID  : return HDR0_P4_ID;
            HDR1_RTL_ID  : return HDR1_P4_ID;
            ECG0_RTL_ID  : return ECG0_P4_ID;
            ECG1_RTL_ID  : return ECG1_P4_ID;
            ECG2_RTL_ID  : return ECG2_P4_ID;
            ECG3_RTL_ID  : return ECG3_P4_ID;
            default      : return NO_PORT_ID;
        endcase
    endfunction

    // P4 egress id -> RTL egress index
    function automatic logic [PORT_ID_W-1:0] p4_to_egress(input logic [PORT_ID_W-1:0] p4_id);
        case (p4_id)
            CPU_P4_ID   : return CPU_RTL_ID;
            OISL0_P4_ID : return OISL0_RTL_ID;
            OISL1_P4_ID : return OISL1_RTL_ID;
            ECP0_P4_ID  : return ECP0_RTL_ID;
            ECP1_P4_ID  : return ECP1_RTL_ID;
            HDR0_P4_ID  : return HDR0_RTL_ID;
            HDR1_P4_ID  : return HDR1_RTL_ID;
            ECG0_P4_ID  : return ECG0_RTL_ID;
            ECG1_P4_ID  : return ECG1_RTL_ID;
            ECG2_P4_ID  : return ECG2_RTL_ID;
            ECG3_P4_ID  : return ECG3_RTL_ID;
            default     : return NO_PORT_ID;
        endcase
    endfunction

endpackage

//--- project.f
hdl/router_port_pkg.sv
hdl/router_ctrl_pkg.sv
hdl/fwd_cam.sv
hdl/ctrl_agent.sv
hdl/lookup_pipe.sv
hdl/p4_router_core.sv
verif/p4_router_tb.sv

//--- verif/p4_router_tb.sv
// testbench for the router match-action stage: table load over req/ack,
// lookups against a model table, clear and back-pressure
`timescale 1ns/10ps

module p4_router_tb;

    localparam int TIMEOUT = 50; // cycles per wait

    logic        clk = 1'b0;
    logic        rst;
    logic        ctrl_req;
    logic [31:0] ctrl_cmd;
    logic        ctrl_ack;
    logic [31:0] ctrl_rdata;
    logic        meta_in_valid;
    logic        meta_in_ready;
    logic [7:0]  meta_in_ing_port;
    logic [15:0] meta_in_key;
    logic        meta_out_valid;
    logic        meta_out_ready;
    logic [7:0]  meta_out_ing_port;
    logic [7:0]  meta_out_egr_spec;

    integer      seed;
    int          err_cnt = 0;
    int          timeout_cnt = 0;
    logic [31:0] rnd;
    logic [31:0] rdata;
    logic        m_valid [16];                     // model table
    logic [15:0] m_key [16];
    logic [7:0]  m_egr [16];
    logic [7:0]  p4_ids [11] = '{8'd0, 8'd20, 8'd21, 8'd40, 8'd41, 8'd60,
                                 8'd61, 8'd80, 8'd81, 8'd82, 8'd83}; // by RTL index

    p4_router_core u_p4_router_core (
        .clk, .rst, .ctrl_req, .ctrl_cmd, .ctrl_ack, .ctrl_rdata,
        .meta_in_valid, .meta_in_ready, .meta_in_ing_port, .meta_in_key,
        .meta_out_valid, .meta_out_ready, .meta_out_ing_port, .meta_out_egr_spec
    );

    always #20 clk = ~clk; // 40 ns period

    //////////////////////////////////////////////////
    // model of the id maps and the table
    function automatic logic [7:0] map_ingress(input logic [7:0] idx);
        if (idx < 8'd11) return p4_ids[idx[3:0]];
        return 8'hFF;                                    // no such RTL port
    endfunction

    function automatic logic [7:0] map_egress(input logic [7:0] p4);
        for (int i = 0; i < 11; i++) if (p4_ids[i] == p4) return 8'(i);
        return 8'hFF;
    endfunction

    function automatic logic [7:0] model_lookup(input logic [15:0] key);
        for (int s = 0; s < 16; s++) if (m_valid[s] && m_key[s] == key) return m_egr[s];
        return 8'd0;                                     // miss goes to CPU
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("Fail %s exp %h got %h", name, exp, got);
        err_cnt++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeout_cnt++;
    endtask

    //////////////////////////////////////////////////
    // control port, one full four-phase transfer
    task automatic ctrl_transfer(input logic [31:0] cmd, output logic [31:0] data);
        int cnt;
        cnt = 0;
        @(negedge clk);
        ctrl_cmd = cmd;
        ctrl_req = 1'b1;
        while (!ctrl_ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!ctrl_ack) report_timeout("ctrl_ack to rise");
        else if (cnt != 2) report_mismatch("ctrl_ack latency", 2, cnt);
        data     = ctrl_rdata;                           // valid while ack high
        ctrl_req = 1'b0;
        cnt = 0;
        while (ctrl_ack && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ctrl_ack) report_timeout("ctrl_ack to fall");
    endtask

    task automatic write_entry(input int slot, input logic [15:0] key, input logic [7:0] egr);
        logic [31:0] dummy;
        m_valid[slot] = 1'b1;
        m_key[slot]   = key;
        m_egr[slot]   = egr;
        ctrl_transfer({2'd1, 4'(slot), 1'b1, egr, key, 1'b0}, dummy);
    endtask

    task automatic clear_entry(input int slot);
        logic [31:0] dummy;
        m_valid[slot] = 1'b0;
        ctrl_transfer({2'd2, 4'(slot), 26'd0}, dummy);
    endtask

    //////////////////////////////////////////////////
    // one lookup, result checked against the model with exact latency
    task automatic lookup_check(input logic [7:0] ing, input logic [15:0] key);
        logic [7:0] exp_ing;
        logic [7:0] exp_egr;
        int         cnt;
        exp_ing = map_ingress(ing);
        exp_egr = map_egress(model_lookup(key));
        cnt = 0;
        @(negedge clk);
        meta_in_valid    = 1'b1;
        meta_in_ing_port = ing;
        meta_in_key      = key;
        #1;
        while (!meta_in_ready && cnt < TIMEOUT) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        if (!meta_in_ready) report_timeout("meta_in_ready");
        @(negedge clk);                                  // taken on the edge before
        meta_in_valid = 1'b0;
        cnt = 1;
        while (!meta_out_valid && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!meta_out_valid) begin
            report_timeout("meta_out_valid");
        end else begin
            if (cnt != 2) report_mismatch("lookup latency", 2, cnt);
            if (meta_out_ing_port !== exp_ing) report_mismatch("meta_out_ing_port", exp_ing,
                                                               meta_out_ing_port);
            if (meta_out_egr_spec !== exp_egr) report_mismatch("meta_out_egr_spec", exp_egr,
                                                               meta_out_egr_spec);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    task automatic reset_state();
        if (ctrl_ack !== 1'b0) report_mismatch("ctrl_ack", 0, ctrl_ack);
        if (meta_out_valid !== 1'b0) report_mismatch("meta_out_valid", 0, meta_out_valid);
        if (meta_in_ready !== 1'b1) report_mismatch("meta_in_ready", 1, meta_in_ready);
        for (int s = 0; s < 16; s += 5) begin            // slots 0, 5, 10, 15
            ctrl_transfer({2'd3, 4'(s), 26'd0}, rdata);
            if (rdata[25] !== 1'b0) report_mismatch("ctrl_rdata.valid", 0, rdata[25]);
        end
    endtask

    task automatic write_readback();
        for (int s = 0; s < 11; s++) begin
            rnd = $random(seed);
            write_entry(s, {rnd[11:0], 4'(s)}, p4_ids[(s * 5 + 3) % 11]); // unique low nibble
        end
        for (int s = 0; s < 11; s++) begin
            ctrl_transfer({2'd3, 4'(s), 26'd0}, rdata);
            if (rdata[31:30] !== 2'd0) report_mismatch("ctrl_rdata.op", 0, rdata[31:30]);
            if (rdata[25] !== 1'b1) report_mismatch("ctrl_rdata.valid", 1, rdata[25]);
            if (rdata[24:17] !== m_egr[s]) report_mismatch("ctrl_rdata.egr", m_egr[s],
                                                           rdata[24:17]);
            if (rdata[16:1] !== m_key[s]) report_mismatch("ctrl_rdata.key", m_key[s],
                                                          rdata[16:1]);
        end
    endtask

    task automatic lookup_hits();
        for (int i = 0; i < 11; i++) lookup_check(8'(i), m_key[i]); // every ingress index
    endtask

    task automatic miss_cases();
        logic [15:0] key;
        key = m_key[0];
        while (model_lookup(key) != 8'd0 || key == m_key[0]) begin // key absent from table
            rnd = $random(seed);
            key = {rnd[11:0], 4'd15};
        end
        lookup_check(8'd1, key);                          // miss, egress CPU
        lookup_check(8'd11, m_key[1]);                    // unmapped ingress
        rnd = $random(seed);
        write_entry(12, {rnd[11:0], 4'd12}, 8'd7);        // P4 id 7 has no RTL port
        lookup_check(8'd2, m_key[12]);
        write_entry(13, m_key[2], p4_ids[9]);             // duplicate, slot 2 must win
        lookup_check(8'd0, m_key[2]);
    endtask

    task automatic clear_slot_lookup();
        clear_entry(4);
        lookup_check(8'd3, m_key[4]);                     // now a miss
        lookup_check(8'd4, m_key[3]);
        lookup_check(8'd5, m_key[5]);
    endtask

    task automatic back_pressure();
        logic [7:0] held_ing;
        logic [7:0] held_egr;
        logic [7:0] exp_ing_q [$];
        logic [7:0] exp_egr_q [$];
        int         sent;
        int         got;
        int         cnt;
        sent = 0;
        got  = 0;
        cnt  = 0;
        @(negedge clk);
        meta_out_ready = 1'b0;
        while (sent < 4 && cnt < TIMEOUT) begin           // fill until the pipe pushes back
            meta_in_valid    = 1'b1;
            meta_in_ing_port = 8'(sent * 3);
            meta_in_key      = m_key[sent + 5];
            #1;
            if (!meta_in_ready) break;
            exp_ing_q.push_back(map_ingress(meta_in_ing_port));
            exp_egr_q.push_back(map_egress(model_lookup(meta_in_key)));
            sent++;
            @(negedge clk);
            cnt++;
        end
        if (sent != 2) report_mismatch("items accepted under back-pressure", 2, sent);
        if (meta_out_valid !== 1'b1) report_mismatch("meta_out_valid", 1, meta_out_valid);
        held_ing = meta_out_ing_port;
        held_egr = meta_out_egr_spec;
        repeat (3) begin
            @(negedge clk);
            #1;
            if (meta_in_ready !== 1'b0) report_mismatch("meta_in_ready", 0, meta_in_ready);
            if (meta_out_ing_port !== held_ing) report_mismatch("meta_out_ing_port", held_ing,
                                                                meta_out_ing_port);
            if (meta_out_egr_spec !== held_egr) report_mismatch("meta_out_egr_spec", held_egr,
                                                                meta_out_egr_spec);
        end
        meta_out_ready = 1'b1;                            // release the sink
        cnt = 0;
        while (got < 4 && cnt < TIMEOUT) begin
            #1;
            if (meta_in_valid && meta_in_ready) begin     // taken on the next edge
                exp_ing_q.push_back(map_ingress(meta_in_ing_port));
                exp_egr_q.push_back(map_egress(model_lookup(meta_in_key)));
                sent++;
            end
            if (meta_out_valid) begin
                if (exp_ing_q.size() == 0) begin
                    $display("output appeared with no request pending");
                    err_cnt++;
                end else begin
                    held_ing = exp_ing_q.pop_front();
                    held_egr = exp_egr_q.pop_front();
                    if (meta_out_ing_port !== held_ing) report_mismatch("meta_out_ing_port",
                        held_ing, meta_out_ing_port);
                    if (meta_out_egr_spec !== held_egr) report_mismatch("meta_out_egr_spec",
                        held_egr, meta_out_egr_spec);
                end
                got++;
            end
            @(negedge clk);
            cnt++;
            meta_in_valid    = (sent < 4);
            meta_in_ing_port = 8'(sent * 3);
            meta_in_key      = m_key[(sent + 5) % 16];
        end
        if (got < 4) report_timeout("back-pressured results");
        meta_in_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    initial begin
        seed             = 32'h1a25b4fe;
        rst              = 1'b1;
        ctrl_req         = 1'b0;
        ctrl_cmd         = '0;
        meta_in_valid    = 1'b0;
        meta_in_ing_port = '0;
        meta_in_key      = '0;
        meta_out_ready   = 1'b1;
        for (int s = 0; s < 16; s++) begin
            m_valid[s] = 1'b0;
            m_key[s]   = '0;
            m_egr[s]   = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_state();
        write_readback();
        lookup_hits();
        miss_cases();
        clear_slot_lookup();
        back_pressure();
        $display("summary: %0d check errors, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
